// File: exec_cluster.f
design/isa_pkg.sv
design/exec_pkg.sv
design/mult_stage.sv
design/mult_unit.sv
design/alu_unit.sv
design/result_merge.sv
design/exec_cluster.sv
verification/clock_gen.sv
verification/exec_tb.sv

// File: Bender.yml
package:
  name: exec_cluster

sources:
  - design/isa_pkg.sv
  - design/exec_pkg.sv
  - design/mult_stage.sv
  - design/mult_unit.sv
  - design/alu_unit.sv
  - design/result_merge.sv
  - design/exec_cluster.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/exec_tb.sv

// File: verification/exec_tb.sv
`timescale 1ns/1ps

module exec_tb
    import isa_pkg::*, exec_pkg::*;
;

    logic          clock;
    logic          reset;
    logic          issue_valid;
    issue_packet_t issue_pack;
    logic          stall;
    fu_packet_t    result_pack;
    logic          data_ready;

    // scoreboard indexed by tag
    data_t expected    [2**TAG_W];
    bit    pending     [2**TAG_W];
    bit    to_mult     [2**TAG_W];
    int    seq_of      [2**TAG_W];
    int    issue_cycle [2**TAG_W];
    int    want_lat    [2**TAG_W]; // -1 when latency is not fixed
    int    last_seq    [2];        // last sequence number seen from alu (0) and multiplier (1)

    tag_t        next_tag;
    int          outstanding;
    int          issue_count;
    int          cycle;
    int          checks;
    int          errors;
    logic [31:0] lfsr;

    data_t corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    clock_gen clock_i (.clock(clock), .reset(reset));

    exec_cluster dut_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pack  (issue_pack),
        .stall       (stall),
        .result_pack (result_pack),
        .data_ready  (data_ready)
    );

    always @(posedge clock) cycle <= cycle + 1;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] w;
        logic        b;
        w = '0;
        for (int k = 0; k < nbits; k++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 32'h8020_0003;
            w = {w[30:0], b};
        end
        return w;
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd1, f3, 5'd3, OP_IMM};
    endfunction

    function automatic logic [31:0] rand_alu_word();
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        f3  = 3'(rand_bits(3));
        alt = 1'(rand_bits(1));
        imm = 12'(rand_bits(12));
        if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = {1'b0, alt, 5'b0}; // shamt form
        if (rand_bits(1) != 0) begin
            return r_word(((f3 == 3'd0 || f3 == 3'd5) && alt) ? 7'h20 : 7'h00, f3);
        end
        return i_word(imm, f3);
    endfunction

    // reference model from the RV32IM rules
    function automatic data_t model(input logic [31:0] word, input data_t a, input data_t b);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        is_op;
        data_t       opb;
        data_t       r;
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] ub;
        logic [63:0] p;
        f7    = word[31:25];
        f3    = word[14:12];
        is_op = (word[6:0] == OP);
        if (is_op && f7 == 7'h01) begin
            sa = {{32{a[31]}}, a};
            sb = {{32{b[31]}}, b};
            ub = {32'b0, b};
            case (f3)
                3'd0:    p = sa * sb;
                3'd1:    p = sa * sb;
                3'd2:    p = sa * ub;
                default: p = {32'b0, a} * ub;
            endcase
            return (f3 == 3'd0) ? p[31:0] : p[63:32];
        end
        opb = is_op ? b : {{20{word[31]}}, word[31:20]};
        case (f3)
            3'd0: r = (is_op && f7[5]) ? a - opb : a + opb;
            3'd1: r = a << opb[4:0];
            3'd2: r = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
            3'd3: r = (a < opb) ? 32'd1 : 32'd0;
            3'd4: r = a ^ opb;
            3'd5: begin
                if (f7[5]) r = $signed(a) >>> opb[4:0];
                else       r = a >> opb[4:0];
            end
            3'd6: r = a | opb;
            default: r = a & opb;
        endcase
        return r;
    endfunction

    task automatic issue(input logic [31:0] word, input data_t a, input data_t b, input int lat);
        tag_t t;
        t = next_tag;
        assert (!pending[t]) else begin
            $display("tag %0d issued again while still outstanding", t);
            errors++;
        end
        expected[t]    = model(word, a, b);
        to_mult[t]     = (word[6:0] == OP) && (word[31:25] == FUNCT7_MULDIV);
        seq_of[t]      = issue_count;
        issue_cycle[t] = cycle;
        want_lat[t]    = lat;
        pending[t]     = 1'b1;
        outstanding++;
        issue_count++;
        next_tag = t + 1'b1;
        issue_valid          = 1'b1;
        issue_pack.inst      = word;
        issue_pack.rs1_value = a;
        issue_pack.rs2_value = b;
        issue_pack.tag       = t;
        @(posedge clock);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic check_completion();
        tag_t t;
        int   lat;
        bit   u;
        t = result_pack.tag;
        assert (pending[t]) else begin
            $display("tag %0d completed twice or was never issued", t);
            errors++;
        end
        if (pending[t]) begin
            checks++;
            assert (result_pack.result == expected[t]) else begin
                $display("CHECK FAILED result_pack.result tag %h: got %h, expected %h",
                         t, result_pack.result, expected[t]);
                errors++;
            end
            lat = cycle - issue_cycle[t];
            assert (want_lat[t] < 0 || lat == want_lat[t]) else begin
                $display("tag %0d completed after %0d cycles instead of %0d",
                         t, lat, want_lat[t]);
                errors++;
            end
            u = to_mult[t];
            assert (seq_of[t] > last_seq[u]) else begin
                $display("tag %0d left ahead of an older result from the same unit", t);
                errors++;
            end
            last_seq[u] = seq_of[t];
            pending[t]  = 1'b0;
            outstanding--;
        end
    endtask

    // outputs are sampled mid-cycle
    always @(negedge clock) begin
        if (!reset && stall) begin
            assert (!data_ready) else begin
                $display("data_ready went high while stall was high");
                errors++;
            end
        end
        if (!reset && data_ready) check_completion();
    end

    task automatic drain();
        int n;
        n = 0;
        while (outstanding != 0 && n < 100) begin
            @(posedge clock);
            #1;
            n++;
        end
        assert (outstanding == 0) else begin
            errors++;
            for (int t = 0; t < 2**TAG_W; t++) begin
                if (pending[t]) $display("tag %0d never completed", t);
                pending[t] = 1'b0;
            end
            outstanding = 0;
        end
    endtask

    task automatic idle_after_reset();
        repeat (4) begin
            assert (!data_ready) else begin
                $display("data_ready high after reset with nothing issued");
                errors++;
            end
            @(posedge clock);
            #1;
        end
    endtask

    task automatic alu_functions();
        logic [6:0]  f7;
        logic [11:0] imm;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f3 == 0 || f3 == 5) begin
                    f7 = (alt != 0) ? 7'h20 : 7'h00;
                    for (int x = 0; x < 5; x++) begin
                        for (int y = 0; y < 5; y++) begin
                            imm = (f3 == 1 || f3 == 5) ? {f7, corners[y][4:0]} : corners[y][11:0];
                            issue(r_word(f7, 3'(f3)), corners[x], corners[y], 1);
                            issue(i_word(imm, 3'(f3)), corners[x], 32'h0, 1);
                        end
                    end
                end
            end
        end
        repeat (40) issue(rand_alu_word(), rand_bits(32), rand_bits(32), 1);
        drain();
    endtask

    task automatic mult_functions();
        for (int f3 = 0; f3 < 4; f3++) begin
            for (int x = 0; x < 5; x++) begin
                for (int y = 0; y < 5; y++) begin
                    issue(r_word(FUNCT7_MULDIV, 3'(f3)), corners[x], corners[y], MULT_STAGES);
                    drain(); // one multiply in flight at a time
                end
            end
        end
    endtask

    task automatic back_to_back_mults();
        repeat (16) begin
            issue(r_word(FUNCT7_MULDIV, 3'(rand_bits(2))), rand_bits(32), rand_bits(32),
                  MULT_STAGES);
        end
        drain();
    endtask

    // alu results land on cycles the multiplier owns the port
    task automatic collision_queue();
        repeat (3) begin
            repeat (MULT_STAGES) begin
                issue(r_word(FUNCT7_MULDIV, 3'(rand_bits(2))), rand_bits(32), rand_bits(32),
                      MULT_STAGES);
            end
            repeat (MULT_STAGES) issue(rand_alu_word(), rand_bits(32), rand_bits(32), -1);
        end
        drain();
    endtask

    task automatic stall_mid_stream();
        repeat (3) issue(r_word(FUNCT7_MULDIV, 3'(rand_bits(2))), rand_bits(32), rand_bits(32), -1);
        issue(rand_alu_word(), rand_bits(32), rand_bits(32), -1);
        stall = 1'b1;
        repeat (6) begin
            @(posedge clock);
            #1;
        end
        stall = 1'b0;
        repeat (3) issue(r_word(FUNCT7_MULDIV, 3'(rand_bits(2))), rand_bits(32), rand_bits(32), -1);
        drain();
    endtask

    initial begin
        int n;
        issue_valid = 1'b0;
        issue_pack  = '0;
        stall       = 1'b0;
        lfsr        = 32'h1bda;
        next_tag    = '0;
        outstanding = 0;
        issue_count = 0;
        cycle       = 0;
        checks      = 0;
        errors      = 0;
        last_seq    = '{-1, -1};
        foreach (pending[t]) pending[t] = 1'b0;
        n = 0;
        while (reset && n < 20) begin
            @(posedge clock);
            n++;
        end
        assert (!reset) else begin
            $display("reset never deasserted");
            errors++;
        end
        #1;
        idle_after_reset();
        alu_functions();
        mult_functions();
        back_to_back_mults();
        collision_queue();
        stall_mid_stream();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verification/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic reset
);

    localparam int HALF_PERIOD  = 5; // 10 ns clock
    localparam int RESET_CYCLES = 2;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// File: design/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster
    import isa_pkg::*, exec_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          issue_valid,
    input  issue_packet_t issue_pack,
    input  logic          stall,
    output fu_packet_t    result_pack,
    output logic          data_ready
);

    logic       is_mult;
    logic       mult_done;
    logic       alu_done;
    fu_packet_t mult_result;
    fu_packet_t alu_result;

    // M group lives under OP with its own funct7, everything else goes to the ALU
    assign is_mult = (issue_pack.inst.r.opcode == OP) &&
                     (issue_pack.inst.r.funct7 == FUNCT7_MULDIV);

    mult_unit mult_i (
        .clock  (clock),
        .reset  (reset),
        .stall  (stall),
        .start  (issue_valid && is_mult),
        .pack   (issue_pack),
        .result (mult_result),
        .done   (mult_done)
    );

    alu_unit alu_i (
        .clock  (clock),
        .reset  (reset),
        .start  (issue_valid && !is_mult),
        .pack   (issue_pack),
        .result (alu_result),
        .done   (alu_done)
    );

    result_merge merge_i (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .mult_done   (mult_done),
        .mult_result (mult_result),
        .alu_done    (alu_done),
        .alu_result  (alu_result),
        .result_pack (result_pack),
        .data_ready  (data_ready)
    );

endmodule

// File: design/result_merge.sv
`timescale 1ns/1ps

module result_merge
    import exec_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       stall,
    input  logic       mult_done,
    input  fu_packet_t mult_result,
    input  logic       alu_done,
    input  fu_packet_t alu_result,
    output fu_packet_t result_pack,
    output logic       data_ready
);

    localparam int PTR_W = $clog2(MULT_STAGES);
    localparam int CNT_W = $clog2(MULT_STAGES + 1);

    fu_packet_t       queue [MULT_STAGES]; // held ALU results
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             queued;
    logic             push;
    logic             pop;

    assign queued = (count != '0);

    // ALU result waits if anything older or the multiplier owns the port
    assign push = alu_done && (stall || mult_done || queued);
    assign pop  = !stall && !mult_done && queued;

    // multiplier first, then the queue head, then a fresh ALU result
    assign result_pack = mult_done ? mult_result :
                         queued    ? queue[head] : alu_result;
    assign data_ready  = !stall && (mult_done || queued || alu_done);

    always_ff @(posedge clock) begin
        if (push) begin
            queue[tail] <= alu_result;
        end
    end

    // depth is a power of two, so the pointers wrap on their own
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= tail + 1'b1;
            if (pop)  head <= head + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: design/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
    import isa_pkg::*, exec_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          start,
    input  issue_packet_t pack,
    output fu_packet_t    result,
    output logic          done
);

    opcode_e     opcode;
    alu_funct3_e funct3;
    logic        alt;     // funct7 bit 5, also imm bit 10 in the I form
    data_t       opa;
    data_t       opb;
    data_t       alu_out;

    assign opcode = pack.inst.r.opcode;
    assign funct3 = alu_funct3_e'(pack.inst.r.funct3);
    assign alt    = pack.inst.r.funct7[5];
    assign opa    = pack.rs1_value;

    // second operand is rs2 or the sign-extended immediate
    assign opb = (opcode == OP) ? pack.rs2_value
                                : {{(XLEN-12){pack.inst.i.imm[11]}}, pack.inst.i.imm};

    always_comb begin
        case (funct3)
            ADD_SUB: alu_out = (opcode == OP && alt) ? opa - opb : opa + opb; // no SUBI
            SLL:     alu_out = opa << opb[4:0];
            SLT:     alu_out = data_t'($signed(opa) < $signed(opb));
            SLTU:    alu_out = data_t'(opa < opb);
            XOR:     alu_out = opa ^ opb;
            SRL_SRA: alu_out = alt ? data_t'($signed(opa) >>> opb[4:0]) : opa >> opb[4:0];
            OR:      alu_out = opa | opb;
            AND:     alu_out = opa & opb;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        result.result <= alu_out;
        result.tag    <= pack.tag;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start; // one cycle latency, independent of stall
        end
    end

endmodule

// File: design/mult_unit.sv
`timescale 1ns/1ps

module mult_unit
    import isa_pkg::*, exec_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          stall,
    input  logic          start,
    input  issue_packet_t pack,
    output fu_packet_t    result,
    output logic          done
);

    // index 0 feeds the first stage, index MULT_STAGES is the last stage output
    logic [MULT_STAGES:0][63:0] sums;
    logic [MULT_STAGES:0][63:0] mpliers;
    logic [MULT_STAGES:0][63:0] mcands;
    logic [MULT_STAGES:0]       valids;
    mult_funct3_e               funcs [MULT_STAGES+1];
    tag_t                       tags  [MULT_STAGES+1];

    mult_funct3_e func;
    data_t        rs1;
    data_t        rs2;

    assign func = mult_funct3_e'(pack.inst.r.funct3);
    assign rs1  = pack.rs1_value;
    assign rs2  = pack.rs2_value;

    // extend operands to 64 bits so one unsigned product covers all four forms
    assign mcands[0]  = (func == M_MULHU) ? {32'b0, rs1}
                                          : {{32{rs1[31]}}, rs1}; // MUL, MULH, MULHSU
    assign mpliers[0] = (func == M_MUL || func == M_MULH) ? {{32{rs2[31]}}, rs2}
                                                          : {32'b0, rs2};

    assign sums[0]   = '0; // running sum starts empty
    assign valids[0] = start;
    assign funcs[0]  = func;
    assign tags[0]   = pack.tag;

    for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
        mult_stage stage_i (
            .clock       (clock),
            .reset       (reset),
            .stall       (stall),
            .start       (valids[i]),
            .func        (funcs[i]),
            .tag         (tags[i]),
            .prev_sum    (sums[i]),
            .mplier      (mpliers[i]),
            .mcand       (mcands[i]),
            .product_sum (sums[i+1]),
            .next_mplier (mpliers[i+1]),
            .next_mcand  (mcands[i+1]),
            .next_func   (funcs[i+1]),
            .next_tag    (tags[i+1]),
            .done        (valids[i+1])
        );
    end

    // low word for MUL, high word for the MULH variants
    assign result.result = (funcs[MULT_STAGES] == M_MUL) ? sums[MULT_STAGES][31:0]
                                                         : sums[MULT_STAGES][63:32];
    assign result.tag    = tags[MULT_STAGES];
    assign done          = valids[MULT_STAGES];

endmodule

// File: design/mult_stage.sv
`timescale 1ns/1ps

module mult_stage
    import isa_pkg::*, exec_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         stall,
    input  logic         start,
    input  mult_funct3_e func,
    input  tag_t         tag,
    input  logic [63:0]  prev_sum,
    input  logic [63:0]  mplier,
    input  logic [63:0]  mcand,
    output logic [63:0]  product_sum,
    output logic [63:0]  next_mplier,
    output logic [63:0]  next_mcand,
    output mult_funct3_e next_func,
    output tag_t         next_tag,
    output logic         done
);

    localparam int SLICE = 64 / MULT_STAGES; // multiplier bits consumed per stage

    logic [63:0] partial_product;

    assign partial_product = 64'(mplier[SLICE-1:0]) * mcand;

    // payload only moves when the pipe advances
    always_ff @(posedge clock) begin
        if (!stall) begin
            product_sum <= prev_sum + partial_product;
            next_mplier <= mplier >> SLICE; // next slice down to the bottom
            next_mcand  <= mcand << SLICE;  // weight the multiplicand to match
            next_func   <= func;
            next_tag    <= tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (!stall) begin
            done <= start;
        end
    end

endmodule

// File: design/exec_pkg.sv
package exec_pkg;

    import isa_pkg::*;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_t;

    localparam int TAG_W = 5; // 32 reorder slots

    typedef logic [TAG_W-1:0] tag_t;

    // depth of the multiplier pipeline
    // must divide 64, so the slice width stays whole
    localparam int MULT_STAGES = 4;

    // what the issue slot hands over each cycle
    typedef struct packed {
        instr_u inst;
        data_t  rs1_value;
        data_t  rs2_value;
        tag_t   tag;
    } issue_packet_t;

    // completion from a function unit and on the writeback port
    typedef struct packed {
        tag_t  tag;
        data_t result;
    } fu_packet_t;

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

    // major opcodes handled by the integer execute cluster
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // register-register
        OP_IMM = 7'b0010011  // register-immediate
    } opcode_e;

    // base integer ops, funct3 field
    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } alu_funct3_e;

    // M extension multiplies, funct3 field (division left out)
    typedef enum logic [2:0] {
        M_MUL    = 3'b000,
        M_MULH   = 3'b001,
        M_MULHSU = 3'b010,
        M_MULHU  = 3'b011
    } mult_funct3_e;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // funct7 of the M group under OP

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    // same word seen as either format
    // funct7 of r overlaps the top of imm in i
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

endpackage
